// File: bench/turf_ctl_asserts.sv
`timescale 1ns/100ps
`include "turf_ctl_macros.svh"

module turf_ctl_asserts (
    input logic                     ps_clk,
    input logic                     reset_i,
    input logic                     awready_o,
    input logic                     bvalid_o,
    input logic [1:0]               bresp_o,
    input logic                     bready_i,
    input logic                     rvalid_o,
    input logic [1:0]               rresp_o,
    input logic [`TURF_DATA_W-1:0]  rdata_o,
    input logic                     rready_i
);

    ////////////////////////////////////////
    // Response channels under back-pressure
    ////////////////////////////////////////

    b_hold: assert property (@(posedge ps_clk) disable iff (reset_i)
        (bvalid_o && !bready_i) |=> (bvalid_o && $stable(bresp_o)))
        else $error("B response dropped or changed while bready was low");

    r_hold: assert property (@(posedge ps_clk) disable iff (reset_i)
        (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rresp_o) && $stable(rdata_o)))
        else $error("R response dropped or changed while rready was low");

    // Only one write in flight
    aw_while_b: assert property (@(posedge ps_clk) disable iff (reset_i)
        !(awready_o && bvalid_o))
        else $error("awready high while a write response is pending");

    no_valid_in_reset: assert property (@(posedge ps_clk)
        reset_i |=> (!bvalid_o && !rvalid_o))
        else $error("valid output high during reset");

endmodule

bind turf_ctl_top turf_ctl_asserts u_asserts (
    .ps_clk    (ps_clk),
    .reset_i   (reset_i),
    .awready_o (awready_o),
    .bvalid_o  (bvalid_o),
    .bresp_o   (bresp_o),
    .bready_i  (bready_i),
    .rvalid_o  (rvalid_o),
    .rresp_o   (rresp_o),
    .rdata_o   (rdata_o),
    .rready_i  (rready_i)
);

// File: bench/turf_ctl_tb.sv
`timescale 1ns/100ps
`include "turf_ctl_macros.svh"

module turf_ctl_tb;

    import turf_ctl_pkg::*;

    localparam int MAX_WAIT     = 16;
    localparam int BRIDGE_LOOPS = 40;
    localparam int GPIO_LOOPS   = 16;
    localparam int STATUS_LOOPS = 16;
    localparam int BAD_LOOPS    = 10;
    localparam int MIX_LOOPS    = 30;
    localparam int TICK_CYCLES  = 5000;
    // Bus transactions issued by all tests together
    localparam int TOTAL_TXN = 2 + 2*BRIDGE_LOOPS + 2*GPIO_LOOPS + STATUS_LOOPS
                               + 2*BAD_LOOPS + 4 + MIX_LOOPS;
    localparam int WATCHDOG_CYCLES = TOTAL_TXN*20 + TICK_CYCLES;

    logic        ps_clk  = 1'b0;
    logic        reset_i = 1'b1;
    logic [7:0]  awaddr_i, araddr_i;
    logic [31:0] wdata_i, rdata_o;
    logic        awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
    logic        awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
    axi_resp_e   bresp_o, rresp_o;
    logic [3:0]  aurora_up_i, bridge_valid_o, turfio_reset_o;
    logic        uart_irq_b_i, hsk_irq_i, hsk_complete_i, gps_timepulse_i;
    logic [7:0]  bridge_type_o;
    logic        gps_extint_o, hsk_16x_o, gps_16x_o;

    // Reference model state
    logic [7:0]  m_types;
    logic [3:0]  m_inv;
    logic [4:0]  m_gpio;

    int   errors = 0;
    int   txns = 0;
    int   test_base = 0;
    int   hsk_count = 0;
    int   gps_count = 0;
    logic tick_done = 1'b0;

    always #2 ps_clk = ~ps_clk;

    turf_ctl_top UUT (.*);

    function automatic logic link_valid(input logic [1:0] t, input logic up);
        return (t == BRIDGE_NONE) || ((t == BRIDGE_AURORA) && up);
    endfunction

    function automatic logic [3:0] expected_valid();
        logic [3:0] v;
        for (int i = 0; i < 4; i++) begin
            v[i] = link_valid(m_types[2*i +: 2], aurora_up_i[i]);
        end
        return v;
    endfunction

    function automatic logic [31:0] expected_bridge();
        return {16'h0, m_inv, expected_valid(), m_types};
    endfunction

    // W1C on the flags, then set for links invalid under their new type
    task automatic apply_bridge_write(input logic [31:0] data);
        logic [1:0] t;
        for (int i = 0; i < 4; i++) begin
            t = data[2*i +: 2];
            m_inv[i] = (m_inv[i] & ~data[12 + i]) |
                       ((t != BRIDGE_NONE) && !link_valid(t, aurora_up_i[i]));
        end
        m_types = data[7:0];
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    ////////////////////////////////////////
    // Bus tasks enter and leave 0.5 ns after a rising edge
    ////////////////////////////////////////

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int lat;
        int delay;
        txns++;
        awaddr_i  = addr;
        wdata_i   = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        lat = 0;
        @(negedge ps_clk);
        while (!awready_o && lat < MAX_WAIT) begin
            @(negedge ps_clk);
            lat++;
        end
        if (!awready_o)
            report_problem($sformatf("write to %h was never accepted", addr));
        else if (wready_o !== 1'b1)
            report_mismatch("wready_o with awready_o", 32'(wready_o), 32'd1);
        @(posedge ps_clk);
        #0.5;
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        lat = 0;
        do begin
            @(negedge ps_clk);
            lat++;
        end while (!bvalid_o && lat < MAX_WAIT);
        if (!bvalid_o)
            report_problem($sformatf("no write response for address %h", addr));
        else if (lat != 2)
            report_mismatch("write response latency", 32'(lat), 32'd2);
        resp = bresp_o;
        delay = $urandom_range(0, 3);
        repeat (delay + 1) @(posedge ps_clk);
        #0.5;
        bready_i = 1'b1;
        @(negedge ps_clk);
        if (!bvalid_o || bresp_o !== resp)
            report_problem("write response not held until bready");
        @(posedge ps_clk);
        #0.5;
        bready_i = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int lat;
        int delay;
        txns++;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        lat = 0;
        @(negedge ps_clk);
        while (!arready_o && lat < MAX_WAIT) begin
            @(negedge ps_clk);
            lat++;
        end
        if (!arready_o)
            report_problem($sformatf("read of %h was never accepted", addr));
        @(posedge ps_clk);
        #0.5;
        arvalid_i = 1'b0;
        lat = 0;
        do begin
            @(negedge ps_clk);
            lat++;
        end while (!rvalid_o && lat < MAX_WAIT);
        if (!rvalid_o)
            report_problem($sformatf("no read response for address %h", addr));
        else if (lat != 2)
            report_mismatch("read response latency", 32'(lat), 32'd2);
        data = rdata_o;
        resp = rresp_o;
        delay = $urandom_range(0, 3);
        repeat (delay + 1) @(posedge ps_clk);
        #0.5;
        rready_i = 1'b1;
        @(negedge ps_clk);
        if (!rvalid_o || rdata_o !== data || rresp_o !== resp)
            report_problem("read response not held until rready");
        @(posedge ps_clk);
        #0.5;
        rready_i = 1'b0;
    endtask

    ////////////////////////////////////////
    // Tick counter starting at the first edge after reset release
    ////////////////////////////////////////

    initial begin
        @(negedge reset_i);
        @(posedge ps_clk);
        repeat (TICK_CYCLES) begin
            @(negedge ps_clk);
            if (hsk_16x_o)
                hsk_count++;
            if (gps_16x_o)
                gps_count++;
        end
        tick_done = 1'b1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ps_clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        logic [31:0] exp_dv;
        logic [15:0] date;
        logic [7:0]  addr;
        int          op;

        void'($urandom(32'hbf0393ef));
        awaddr_i = '0;
        araddr_i = '0;
        wdata_i = '0;
        awvalid_i = 1'b0;
        wvalid_i = 1'b0;
        bready_i = 1'b0;
        arvalid_i = 1'b0;
        rready_i = 1'b0;
        aurora_up_i = '0;
        uart_irq_b_i = 1'b1;
        hsk_irq_i = 1'b0;
        hsk_complete_i = 1'b0;
        gps_timepulse_i = 1'b0;
        m_types = '0;
        m_inv = '0;
        m_gpio = '0;
        repeat (4) @(posedge ps_clk);
        #0.5;
        reset_i = 1'b0;

        // Identification and date/version word
        read_reg(`TURF_REG_ID, data, resp);
        if (data !== `TURF_IDENT)
            report_mismatch("ID readback", data, `TURF_IDENT);
        if (resp !== RESP_OKAY)
            report_mismatch("ID response", 32'(resp), 32'(RESP_OKAY));
        date   = `TURF_FW_DATE;
        exp_dv = (32'(`TURF_REV_B) << 31) | (32'(date[14:0]) << 16) |
                 (32'(`TURF_VER_MAJOR) << 12) | (32'(`TURF_VER_MINOR) << 8) |
                 32'(`TURF_VER_REV);
        read_reg(`TURF_REG_DATEVER, data, resp);
        if (data !== exp_dv)
            report_mismatch("DATEVER readback", data, exp_dv);
        if (resp !== RESP_OKAY)
            report_mismatch("DATEVER response", 32'(resp), 32'(RESP_OKAY));
        report_test("1 id and version");

        for (int n = 0; n < BRIDGE_LOOPS; n++) begin
            aurora_up_i = 4'($urandom());
            data = $urandom();
            write_reg(`TURF_REG_BRIDGE, data, resp);
            apply_bridge_write(data);
            if (resp !== RESP_OKAY)
                report_mismatch("BRIDGE write response", 32'(resp), 32'(RESP_OKAY));
            // Links may go up or down after the write
            aurora_up_i = 4'($urandom());
            read_reg(`TURF_REG_BRIDGE, data, resp);
            if (data !== expected_bridge())
                report_mismatch("BRIDGE readback", data, expected_bridge());
            if (bridge_type_o !== m_types)
                report_mismatch("bridge_type_o", 32'(bridge_type_o), 32'(m_types));
            if (bridge_valid_o !== expected_valid())
                report_mismatch("bridge_valid_o", 32'(bridge_valid_o), 32'(expected_valid()));
        end
        report_test("2 bridge select");

        for (int n = 0; n < GPIO_LOOPS; n++) begin
            data = $urandom();
            write_reg(`TURF_REG_GPIO, data, resp);
            m_gpio = data[4:0];
            if (turfio_reset_o !== m_gpio[3:0])
                report_mismatch("turfio_reset_o", 32'(turfio_reset_o), 32'(m_gpio[3:0]));
            if (gps_extint_o !== m_gpio[4])
                report_mismatch("gps_extint_o", 32'(gps_extint_o), 32'(m_gpio[4]));
            read_reg(`TURF_REG_GPIO, data, resp);
            if (data !== {27'h0, m_gpio})
                report_mismatch("GPIO readback", data, {27'h0, m_gpio});
        end
        for (int n = 0; n < STATUS_LOOPS; n++) begin
            {gps_timepulse_i, hsk_complete_i, hsk_irq_i, uart_irq_b_i} = 4'($urandom());
            read_reg(`TURF_REG_STATUS, data, resp);
            if (data !== {28'h0, gps_timepulse_i, hsk_complete_i, hsk_irq_i, uart_irq_b_i})
                report_mismatch("STATUS readback", data,
                    {28'h0, gps_timepulse_i, hsk_complete_i, hsk_irq_i, uart_irq_b_i});
        end
        report_test("3 gpio and status");

        for (int n = 0; n < BAD_LOOPS; n++) begin
            addr = 8'($urandom_range(32'h14, 32'hFF));
            write_reg(addr, $urandom(), resp);
            if (resp !== RESP_SLVERR)
                report_mismatch("unmapped write response", 32'(resp), 32'(RESP_SLVERR));
            read_reg(addr, data, resp);
            if (resp !== RESP_SLVERR)
                report_mismatch("unmapped read response", 32'(resp), 32'(RESP_SLVERR));
            if (data !== 32'h0)
                report_mismatch("unmapped read data", data, 32'h0);
        end
        // Read-only register takes the write and keeps its value
        write_reg(`TURF_REG_ID, $urandom(), resp);
        if (resp !== RESP_OKAY)
            report_mismatch("ID write response", 32'(resp), 32'(RESP_OKAY));
        read_reg(`TURF_REG_ID, data, resp);
        if (data !== `TURF_IDENT)
            report_mismatch("ID after write", data, `TURF_IDENT);
        read_reg(`TURF_REG_BRIDGE, data, resp);
        if (data !== expected_bridge())
            report_mismatch("BRIDGE after unmapped writes", data, expected_bridge());
        read_reg(`TURF_REG_GPIO, data, resp);
        if (data !== {27'h0, m_gpio})
            report_mismatch("GPIO after unmapped writes", data, {27'h0, m_gpio});
        report_test("4 unmapped addresses");

        for (int n = 0; n < MIX_LOOPS; n++) begin
            op = $urandom_range(0, 3);
            case (op)
                0: begin
                    aurora_up_i = 4'($urandom());
                    data = $urandom();
                    write_reg(`TURF_REG_BRIDGE, data, resp);
                    apply_bridge_write(data);
                    if (resp !== RESP_OKAY)
                        report_mismatch("mixed BRIDGE write", 32'(resp), 32'(RESP_OKAY));
                end
                1: begin
                    data = $urandom();
                    write_reg(`TURF_REG_GPIO, data, resp);
                    m_gpio = data[4:0];
                    if (resp !== RESP_OKAY)
                        report_mismatch("mixed GPIO write", 32'(resp), 32'(RESP_OKAY));
                end
                2: begin
                    read_reg(`TURF_REG_BRIDGE, data, resp);
                    if (data !== expected_bridge())
                        report_mismatch("mixed BRIDGE read", data, expected_bridge());
                end
                default: begin
                    read_reg(`TURF_REG_GPIO, data, resp);
                    if (data !== {27'h0, m_gpio})
                        report_mismatch("mixed GPIO read", data, {27'h0, m_gpio});
                end
            endcase
        end
        report_test("5 back-pressure");

        // Expected counts are floor(82N/1024) and floor(25N/4096)
        wait (tick_done);
        if (hsk_count != (82 * TICK_CYCLES) / 1024)
            report_mismatch("hsk_16x_o count", 32'(hsk_count), 32'((82 * TICK_CYCLES) / 1024));
        if (gps_count != (25 * TICK_CYCLES) / 4096)
            report_mismatch("gps_16x_o count", 32'(gps_count), 32'((25 * TICK_CYCLES) / 4096));
        report_test("6 baud ticks");

        $display("tests 6, transactions %0d, errors %0d", txns, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/turf_ctl_baud_tick.sv
`timescale 1ns/100ps
`include "turf_ctl_macros.svh"

module turf_ctl_baud_tick (
    input  logic ps_clk,
    input  logic reset_i,
    output logic hsk_16x_o,
    output logic gps_16x_o
);

    // Top bit of each accumulator holds the carry of the last add
    logic [`TURF_HSK_ACC_W:0] hsk_acc;
    logic [`TURF_GPS_ACC_W:0] gps_acc;

    // 82/1024 of 100 MHz is within 0.1% of 8 MHz
    // 25/4096 gives 38400 baud times 16
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            hsk_acc <= '0;
            gps_acc <= '0;
        end else begin
            hsk_acc <= {1'b0, hsk_acc[`TURF_HSK_ACC_W-1:0]} + `TURF_HSK_ADD;
            gps_acc <= {1'b0, gps_acc[`TURF_GPS_ACC_W-1:0]} + `TURF_GPS_ADD;
        end
    end

    assign hsk_16x_o = hsk_acc[`TURF_HSK_ACC_W];
    assign gps_16x_o = gps_acc[`TURF_GPS_ACC_W];

endmodule

// File: hdl/turf_ctl_decode.sv
`timescale 1ns/100ps
`include "turf_ctl_macros.svh"

module turf_ctl_decode (
    input  logic                        ps_clk,
    input  logic                        reset_i,
    input  logic [`TURF_ADDR_W-1:0]     awaddr_i,
    input  logic                        awvalid_i,
    input  logic [`TURF_DATA_W-1:0]     wdata_i,
    input  logic                        wvalid_i,
    input  logic [`TURF_ADDR_W-1:0]     araddr_i,
    input  logic                        arvalid_i,
    input  logic                        wr_busy_i,
    input  logic                        rd_busy_i,
    output logic                        awready_o,
    output logic                        wready_o,
    output logic                        arready_o,
    output logic                        wr_en_o,
    output turf_ctl_pkg::reg_sel_e      wr_sel_o,
    output logic [`TURF_DATA_W-1:0]     wr_data_o,
    output logic                        rd_en_o,
    output turf_ctl_pkg::reg_sel_e      rd_sel_o
);

    import turf_ctl_pkg::*;

    // Word address to register select, byte lanes ignored
    function automatic reg_sel_e addr_to_sel(input logic [`TURF_ADDR_W-1:0] addr);
        logic [`TURF_ADDR_W-1:0] word;
        word = {addr[`TURF_ADDR_W-1:2], 2'b00};
        case (word)
            `TURF_REG_ID:      return REG_ID;
            `TURF_REG_DATEVER: return REG_DATEVER;
            `TURF_REG_BRIDGE:  return REG_BRIDGE;
            `TURF_REG_GPIO:    return REG_GPIO;
            `TURF_REG_STATUS:  return REG_STATUS;
            default:           return REG_NONE;
        endcase
    endfunction

    ////////////////////////////////////////
    // Channel acceptance
    ////////////////////////////////////////

    // AW and W are taken together in a single cycle
    assign awready_o = awvalid_i & wvalid_i & ~wr_busy_i;
    assign wready_o  = awready_o;
    assign arready_o = arvalid_i & ~rd_busy_i;

    ////////////////////////////////////////
    // Access pulses and payload
    ////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            wr_en_o <= 1'b0;
            rd_en_o <= 1'b0;
        end else begin
            wr_en_o <= awready_o;
            rd_en_o <= arready_o;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (awready_o) begin
            wr_sel_o  <= addr_to_sel(awaddr_i);
            wr_data_o <= wdata_i;
        end
        if (arready_o) begin
            rd_sel_o <= addr_to_sel(araddr_i);
        end
    end

endmodule

// File: hdl/turf_ctl_execute.sv
`timescale 1ns/100ps
`include "turf_ctl_macros.svh"

module turf_ctl_execute (
    input  logic                            ps_clk,
    input  logic                            reset_i,
    input  logic                            wr_en_i,
    input  turf_ctl_pkg::reg_sel_e          wr_sel_i,
    input  logic [`TURF_DATA_W-1:0]         wr_data_i,
    input  turf_ctl_pkg::reg_sel_e          rd_sel_i,
    input  logic [`TURF_NUM_LINKS-1:0]      aurora_up_i,
    input  logic                            uart_irq_b_i,
    input  logic                            hsk_irq_i,
    input  logic                            hsk_complete_i,
    input  logic                            gps_timepulse_i,
    output logic [`TURF_DATA_W-1:0]         rd_data_o,
    output logic [2*`TURF_NUM_LINKS-1:0]    bridge_type_o,
    output logic [`TURF_NUM_LINKS-1:0]      bridge_valid_o,
    output logic [`TURF_NUM_LINKS-1:0]      turfio_reset_o,
    output logic                            gps_extint_o
);

    import turf_ctl_pkg::*;

    localparam int NL = `TURF_NUM_LINKS;
    localparam logic [15:0] FW_DATE = `TURF_FW_DATE;
    localparam logic [31:0] DATEVER = {`TURF_REV_B, FW_DATE[14:0],
                                       `TURF_VER_MAJOR, `TURF_VER_MINOR, `TURF_VER_REV};

    bridge_type_e    link_type [NL];
    bridge_type_e    new_type [NL];
    logic [NL-1:0]   invalid_q;
    logic [NL-1:0]   new_invalid;

    // NONE is always reachable, AURORA only once its link is up
    function automatic logic link_ok(input bridge_type_e t, input logic up);
        return (t == BRIDGE_NONE) || ((t == BRIDGE_AURORA) && up);
    endfunction

    ////////////////////////////////////////
    // Bridge selection and validity
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NL; i++) begin
            bridge_type_o[2*i +: 2] = link_type[i];
            bridge_valid_o[i]       = link_ok(link_type[i], aurora_up_i[i]);
        end
    end

    // Clear written flags first, then flag links invalid under their new type
    always_comb begin
        for (int i = 0; i < NL; i++) begin
            new_type[i]    = bridge_type_e'(wr_data_i[2*i +: 2]);
            new_invalid[i] = (invalid_q[i] & ~wr_data_i[`TURF_BRIDGE_INV_LSB + i]) |
                             ((new_type[i] != BRIDGE_NONE) &
                              ~link_ok(new_type[i], aurora_up_i[i]));
        end
    end

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            for (int i = 0; i < NL; i++) begin
                link_type[i] <= BRIDGE_NONE;
            end
            invalid_q      <= '0;
            turfio_reset_o <= '0;
            gps_extint_o   <= 1'b0;
        end else if (wr_en_i) begin
            case (wr_sel_i)
                REG_BRIDGE: begin
                    for (int i = 0; i < NL; i++) begin
                        link_type[i] <= new_type[i];
                    end
                    invalid_q <= new_invalid;
                end
                REG_GPIO: begin
                    turfio_reset_o <= wr_data_i[NL-1:0];
                    gps_extint_o   <= wr_data_i[NL];
                end
                // ID, DATEVER and STATUS ignore writes
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        rd_data_o = '0;
        case (rd_sel_i)
            REG_ID:      rd_data_o = `TURF_IDENT;
            REG_DATEVER: rd_data_o = DATEVER;
            REG_BRIDGE: begin
                rd_data_o[2*NL-1:0] = bridge_type_o;
                rd_data_o[`TURF_BRIDGE_VALID_LSB +: NL] = bridge_valid_o;
                rd_data_o[`TURF_BRIDGE_INV_LSB +: NL]   = invalid_q;
            end
            REG_GPIO:    rd_data_o[NL:0] = {gps_extint_o, turfio_reset_o};
            REG_STATUS:  rd_data_o[3:0] = {gps_timepulse_i, hsk_complete_i,
                                           hsk_irq_i, uart_irq_b_i};
            default:     rd_data_o = '0;
        endcase
    end

endmodule

// File: hdl/turf_ctl_macros.svh
`ifndef TURF_CTL_MACROS_SVH
`define TURF_CTL_MACROS_SVH

// Bus and link geometry
`define TURF_ADDR_W         8
`define TURF_DATA_W         32
`define TURF_NUM_LINKS      4

// Register offsets, byte addressed
`define TURF_REG_ID         8'h00
`define TURF_REG_DATEVER    8'h04
`define TURF_REG_BRIDGE     8'h08
`define TURF_REG_GPIO       8'h0C
`define TURF_REG_STATUS     8'h10

// BRIDGE register field positions
`define TURF_BRIDGE_VALID_LSB   8
`define TURF_BRIDGE_INV_LSB     12

// Identification and version
`define TURF_IDENT          32'h54555246
`define TURF_VER_MAJOR      4'd0
`define TURF_VER_MINOR      4'd7
`define TURF_VER_REV        8'd23
`define TURF_FW_DATE        16'h1A2B
`define TURF_REV_B          1'b0

// 16x tick accumulators
`define TURF_HSK_ACC_W      10
`define TURF_HSK_ADD        10'd82
`define TURF_GPS_ACC_W      12
`define TURF_GPS_ADD        12'd25

`endif

// File: hdl/turf_ctl_pkg.sv
package turf_ctl_pkg;

    // Target of a decoded register access
    typedef enum logic [2:0] {
        REG_ID      = 3'd0,
        REG_DATEVER = 3'd1,
        REG_BRIDGE  = 3'd2,
        REG_GPIO    = 3'd3,
        REG_STATUS  = 3'd4,
        REG_NONE    = 3'd7
    } reg_sel_e;

    // Crate register bridge type, one per TURFIO link
    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_e;

    // AXI4-Lite response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } axi_resp_e;

endpackage

// File: hdl/turf_ctl_result.sv
`timescale 1ns/100ps
`include "turf_ctl_macros.svh"

module turf_ctl_result (
    input  logic                        ps_clk,
    input  logic                        reset_i,
    input  logic                        wr_en_i,
    input  turf_ctl_pkg::reg_sel_e      wr_sel_i,
    input  logic                        rd_en_i,
    input  turf_ctl_pkg::reg_sel_e      rd_sel_i,
    input  logic [`TURF_DATA_W-1:0]     rd_data_i,
    input  logic                        bready_i,
    input  logic                        rready_i,
    output logic                        bvalid_o,
    output turf_ctl_pkg::axi_resp_e     bresp_o,
    output logic                        rvalid_o,
    output turf_ctl_pkg::axi_resp_e     rresp_o,
    output logic [`TURF_DATA_W-1:0]     rdata_o,
    output logic                        wr_busy_o,
    output logic                        rd_busy_o
);

    import turf_ctl_pkg::*;

    // A channel is pending from its access pulse until the response handshake
    assign wr_busy_o = wr_en_i | bvalid_o;
    assign rd_busy_o = rd_en_i | rvalid_o;

    ////////////////////////////////////////
    // B channel
    ////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            bvalid_o <= 1'b0;
        end else if (wr_en_i) begin
            bvalid_o <= 1'b1;
        end else if (bready_i) begin
            bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (wr_en_i) begin
            bresp_o <= (wr_sel_i == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    ////////////////////////////////////////
    // R channel
    ////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            rvalid_o <= 1'b0;
        end else if (rd_en_i) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    // Unmapped reads return zero
    always_ff @(posedge ps_clk) begin
        if (rd_en_i) begin
            rresp_o <= (rd_sel_i == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
            rdata_o <= (rd_sel_i == REG_NONE) ? '0 : rd_data_i;
        end
    end

endmodule

// File: hdl/turf_ctl_top.sv
`timescale 1ns/100ps
`include "turf_ctl_macros.svh"

module turf_ctl_top (
    input  logic                            ps_clk,
    input  logic                            reset_i,
    // AXI4-Lite slave
    input  logic [`TURF_ADDR_W-1:0]         awaddr_i,
    input  logic                            awvalid_i,
    output logic                            awready_o,
    input  logic [`TURF_DATA_W-1:0]         wdata_i,
    input  logic                            wvalid_i,
    output logic                            wready_o,
    output logic                            bvalid_o,
    output turf_ctl_pkg::axi_resp_e         bresp_o,
    input  logic                            bready_i,
    input  logic [`TURF_ADDR_W-1:0]         araddr_i,
    input  logic                            arvalid_i,
    output logic                            arready_o,
    output logic                            rvalid_o,
    output turf_ctl_pkg::axi_resp_e         rresp_o,
    output logic [`TURF_DATA_W-1:0]         rdata_o,
    input  logic                            rready_i,
    // Link status and housekeeping inputs
    input  logic [`TURF_NUM_LINKS-1:0]      aurora_up_i,
    input  logic                            uart_irq_b_i,
    input  logic                            hsk_irq_i,
    input  logic                            hsk_complete_i,
    input  logic                            gps_timepulse_i,
    // Control outputs
    output logic [2*`TURF_NUM_LINKS-1:0]    bridge_type_o,
    output logic [`TURF_NUM_LINKS-1:0]      bridge_valid_o,
    output logic [`TURF_NUM_LINKS-1:0]      turfio_reset_o,
    output logic                            gps_extint_o,
    output logic                            hsk_16x_o,
    output logic                            gps_16x_o
);

    import turf_ctl_pkg::*;

    logic                       wr_en;
    reg_sel_e                   wr_sel;
    logic [`TURF_DATA_W-1:0]    wr_data;
    logic                       rd_en;
    reg_sel_e                   rd_sel;
    logic [`TURF_DATA_W-1:0]    rd_data;
    logic                       wr_busy;
    logic                       rd_busy;

    ////////////////////////////////////////
    // Register access pipeline
    ////////////////////////////////////////

    turf_ctl_decode u_decode (
        .ps_clk    (ps_clk),
        .reset_i   (reset_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .wr_busy_i (wr_busy),
        .rd_busy_i (rd_busy),
        .awready_o (awready_o),
        .wready_o  (wready_o),
        .arready_o (arready_o),
        .wr_en_o   (wr_en),
        .wr_sel_o  (wr_sel),
        .wr_data_o (wr_data),
        .rd_en_o   (rd_en),
        .rd_sel_o  (rd_sel)
    );

    turf_ctl_execute u_execute (
        .ps_clk          (ps_clk),
        .reset_i         (reset_i),
        .wr_en_i         (wr_en),
        .wr_sel_i        (wr_sel),
        .wr_data_i       (wr_data),
        .rd_sel_i        (rd_sel),
        .aurora_up_i     (aurora_up_i),
        .uart_irq_b_i    (uart_irq_b_i),
        .hsk_irq_i       (hsk_irq_i),
        .hsk_complete_i  (hsk_complete_i),
        .gps_timepulse_i (gps_timepulse_i),
        .rd_data_o       (rd_data),
        .bridge_type_o   (bridge_type_o),
        .bridge_valid_o  (bridge_valid_o),
        .turfio_reset_o  (turfio_reset_o),
        .gps_extint_o    (gps_extint_o)
    );

    turf_ctl_result u_result (
        .ps_clk    (ps_clk),
        .reset_i   (reset_i),
        .wr_en_i   (wr_en),
        .wr_sel_i  (wr_sel),
        .rd_en_i   (rd_en),
        .rd_sel_i  (rd_sel),
        .rd_data_i (rd_data),
        .bready_i  (bready_i),
        .rready_i  (rready_i),
        .bvalid_o  (bvalid_o),
        .bresp_o   (bresp_o),
        .rvalid_o  (rvalid_o),
        .rresp_o   (rresp_o),
        .rdata_o   (rdata_o),
        .wr_busy_o (wr_busy),
        .rd_busy_o (rd_busy)
    );

    // Debug UART 16x ticks
    turf_ctl_baud_tick u_baud_tick (
        .ps_clk    (ps_clk),
        .reset_i   (reset_i),
        .hsk_16x_o (hsk_16x_o),
        .gps_16x_o (gps_16x_o)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the turf_ctl testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f turf_ctl.f --top-module turf_ctl_tb -o turf_ctl_sim
./obj_dir/turf_ctl_sim 2>&1 | tee "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

// File: turf_ctl.f
+incdir+hdl
hdl/turf_ctl_pkg.sv
hdl/turf_ctl_decode.sv
hdl/turf_ctl_execute.sv
hdl/turf_ctl_result.sv
hdl/turf_ctl_baud_tick.sv
hdl/turf_ctl_top.sv
bench/turf_ctl_asserts.sv
bench/turf_ctl_tb.sv
